// File: all.f
+incdir+.
rv_pkg.sv
rv_fetch_buffer.sv
rv_predecode.sv
rv_decode.sv
rv_operand_read.sv
rv_frontend.sv
tb_frontend.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_frontend -o sim_frontend

# the log decides the result, so a failing run must not stop the script here
./obj_dir/sim_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

// File: tb_model.svh
// reference model for the front end testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

word_t reg_model [32] = '{default: '0}; // entry 0 is never written

function automatic instr_format_t model_format(input word_t instr);
	instr_format_t fmt;
	case (instr[6:0])
		OP:                              fmt = FMT_R;
		JALR, LOAD, OP_IMM, MISC_MEM:    fmt = FMT_I;
		STORE:                           fmt = FMT_S;
		BRANCH:                          fmt = FMT_B;
		LUI, AUIPC:                      fmt = FMT_U;
		JAL:                             fmt = FMT_J;
		SYSTEM:                          fmt = FMT_CSR;
		default:                         fmt = FMT_NONE;
	endcase
	return fmt;
endfunction

// start from all sign bits, then overwrite the low fields
function automatic word_t model_imm(input word_t instr, input instr_format_t fmt);
	word_t imm;
	imm = {32{instr[31]}};
	case (fmt)
		FMT_I: imm[11:0] = instr[31:20];
		FMT_S: begin
			imm[11:5] = instr[31:25];
			imm[4:0] = instr[11:7];
		end
		FMT_B: begin
			imm[11] = instr[7];
			imm[10:5] = instr[30:25];
			imm[4:1] = instr[11:8];
			imm[0] = 1'b0;
		end
		FMT_J: begin
			imm[19:12] = instr[19:12];
			imm[11] = instr[20];
			imm[10:1] = instr[30:21];
			imm[0] = 1'b0;
		end
		FMT_U:   imm = instr & 32'hffff_f000;
		FMT_CSR: imm = instr >> 20;
		default: imm = '0;
	endcase
	return imm;
endfunction

function automatic alu_op_t model_op(input word_t instr);
	alu_op_t op;
	alu_op_t branch_ops [8];
	alu_op_t alu_ops [8];
	logic [3:0] sel; // bit 30 above funct3
	branch_ops = '{BEQ, BNE, INVALID_OP, INVALID_OP, BLT, BGE, BLTU, BGEU};
	alu_ops = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
	sel = {instr[30], instr[14:12]};
	op = INVALID_OP;
	case (instr[6:0])
		LUI:      op = LUI_OP;
		AUIPC:    op = AUIPC_OP;
		JAL:      op = JAL_OP;
		JALR:     op = (sel[2:0] == 3'd0) ? JALR_OP : INVALID_OP;
		BRANCH:   op = branch_ops[sel[2:0]];
		LOAD:     op = (sel[2:0] inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? LOAD_OP : INVALID_OP;
		STORE:    op = (sel[2:0] <= 3'd2) ? STORE_OP : INVALID_OP;
		OP_IMM:   op = (sel == 4'b1101) ? SRA : (sel == 4'b1001) ? INVALID_OP : alu_ops[sel[2:0]];
		OP:       op = (sel == 4'b1000) ? SUB : (sel == 4'b1101) ? SRA :
			sel[3] ? INVALID_OP : alu_ops[sel[2:0]];
		MISC_MEM: op = (sel[2:0] == 3'd0) ? FENCE_OP : INVALID_OP;
		SYSTEM:   op = (sel[2:0] != 3'd0) ? CSR_OP : INVALID_OP;
		default:  op = INVALID_OP;
	endcase
	return op;
endfunction

// expected issue item for a word, operands from the register model
function automatic issue_t model_item(input word_t pc, input word_t instr);
	issue_t item;
	instr_format_t fmt;
	fmt = model_format(instr);
	item = '0;
	item.decoded.fetch.pc = pc;
	item.decoded.fetch.instruction = instr;
	item.decoded.fetch.format = fmt;
	if (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B, FMT_CSR})
		item.decoded.fetch.rs1 = instr[19:15];
	if (fmt inside {FMT_R, FMT_S, FMT_B})
		item.decoded.fetch.rs2 = instr[24:20];
	if (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J, FMT_CSR})
		item.decoded.fetch.rd = instr[11:7];
	item.decoded.fetch.imm = model_imm(instr, fmt);
	item.decoded.op = model_op(instr);
	item.rs1_value = reg_model[item.decoded.fetch.rs1];
	item.rs2_value = reg_model[item.decoded.fetch.rs2];
	return item;
endfunction

`endif

// File: tb_frontend.sv
// front end testbench
module tb_frontend import rv_pkg::*; ();

	localparam word_t reset_pc = 32'h0000_1000;
	localparam int num_instr = 292; // instructions sent over all tests

	logic      i_clock = 1'b0;
	logic      i_reset;
	logic      i_instr_valid;
	word_t     i_instr;
	logic      i_redirect;
	word_t     i_redirect_pc;
	logic      i_issue_ready = 1'b1;
	logic      i_wb_enable;
	register_t i_wb_rd;
	word_t     i_wb_data;
	logic      o_instr_ready;
	logic      o_issue_valid;
	issue_t    o_issue;

	issue_t     got_q [$];
	issue_t     exp_q [$];
	int         checked = 0; // items already compared
	word_t      pc_model;
	logic       stall_mode = 1'b0;
	logic [6:0] opcodes [12] = '{LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP,
		SYSTEM, MISC_MEM, 7'b1111111};

	`include "tb_model.svh"

	rv_frontend #(.reset_pc(reset_pc)) dut0 (.*);

	always #4 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		if (!i_reset && o_issue_valid && i_issue_ready)
			got_q.push_back(o_issue);
	end

	always @(negedge i_clock)
		i_issue_ready = stall_mode ? ($urandom_range(0, 1) == 1) : 1'b1;

	initial begin
		#(8 * (num_instr * 20 + 200));
		$display("timeout, the DUT stopped issuing instructions");
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got == exp) else begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic compare_item(input issue_t g, input issue_t e);
		check_word("o_issue.pc", g.decoded.fetch.pc, e.decoded.fetch.pc);
		check_word("o_issue.instruction", g.decoded.fetch.instruction,
			e.decoded.fetch.instruction);
		check_word("o_issue.format", 32'(g.decoded.fetch.format), 32'(e.decoded.fetch.format));
		check_word("o_issue.rs1", 32'(g.decoded.fetch.rs1), 32'(e.decoded.fetch.rs1));
		check_word("o_issue.rs2", 32'(g.decoded.fetch.rs2), 32'(e.decoded.fetch.rs2));
		check_word("o_issue.rd", 32'(g.decoded.fetch.rd), 32'(e.decoded.fetch.rd));
		check_word("o_issue.imm", g.decoded.fetch.imm, e.decoded.fetch.imm);
		check_word("o_issue.op", 32'(g.decoded.op), 32'(e.decoded.op));
		check_word("o_issue.rs1_value", g.rs1_value, e.rs1_value);
		check_word("o_issue.rs2_value", g.rs2_value, e.rs2_value);
	endtask

	// wait for every expected item, then make sure nothing extra follows
	task automatic drain_and_check();
		while (got_q.size() < exp_q.size())
			@(posedge i_clock);
		repeat (10) @(negedge i_clock);
		check_word("issued item count", 32'(got_q.size()), 32'(exp_q.size()));
		for (int i = checked; i < exp_q.size(); i++)
			compare_item(got_q[i], exp_q[i]);
		checked = exp_q.size();
	endtask

	task automatic send_word(input word_t w);
		exp_q.push_back(model_item(pc_model, w));
		pc_model = pc_model + 32'd4;
		i_instr_valid = 1'b1;
		i_instr = w;
		@(posedge i_clock);
		while (!o_instr_ready)
			@(posedge i_clock);
		@(negedge i_clock);
		i_instr_valid = 1'b0;
	endtask

	task automatic write_reg(input register_t rd, input word_t v);
		i_wb_enable = 1'b1;
		i_wb_rd = rd;
		i_wb_data = v;
		if (rd != 5'd0)
			reg_model[rd] = v;
		@(negedge i_clock);
		i_wb_enable = 1'b0;
	endtask

	function automatic word_t word_with_opcode(input logic [6:0] opc);
		word_t w;
		w = $urandom;
		w[6:0] = opc;
		return w;
	endfunction

	// write lands on the edge where the item enters operand read
	task automatic capture_bypass(input register_t r);
		word_t v;
		word_t w;
		v = $urandom;
		w = word_with_opcode(OP);
		w[19:15] = r;
		w[24:20] = r;
		if (r != 5'd0)
			reg_model[r] = v;
		send_word(w);
		repeat (2) @(negedge i_clock);
		write_reg(r, v);
		drain_and_check();
	endtask

	task automatic test_registers();
		word_t w;
		for (int n = 0; n < 31; n++)
			write_reg(5'(n + 1), $urandom);
		for (int n = 0; n < 6; n++)
			write_reg(5'($urandom), $urandom);
		write_reg(5'd0, 32'hdead_beef); // must not stick
		for (int n = 0; n < 10; n++)
			send_word(word_with_opcode(OP));
		w = word_with_opcode(OP);
		w[19:15] = 5'd0;
		w[24:20] = 5'd0;
		send_word(w);
		drain_and_check();
		capture_bypass(5'($urandom_range(1, 31)));
		capture_bypass(5'd0);
	endtask

	task automatic test_formats(); // formats, immediates, index masking
		for (int k = 0; k < 3; k++)
			for (int n = 0; n < 12; n++)
				send_word(word_with_opcode(opcodes[n]));
		drain_and_check();
	endtask

	task automatic test_decode();
		word_t w;
		for (int n = 0; n < 12; n++) begin
			for (int sel = 0; sel < 16; sel++) begin
				w = word_with_opcode(opcodes[n]);
				w[14:12] = 3'(sel);
				w[30] = sel[3];
				send_word(w);
			end
		end
		drain_and_check();
	endtask

	task automatic test_backpressure();
		int idx;
		stall_mode = 1'b1;
		for (int n = 0; n < 40; n++) begin
			idx = $urandom_range(0, 11);
			send_word(word_with_opcode(opcodes[idx]));
		end
		stall_mode = 1'b0;
		drain_and_check();
	endtask

	// fetch, pre-decode and decode each hold one burst item on the redirect edge
	task automatic test_redirect();
		word_t target;
		int kept;
		for (int n = 0; n < 6; n++)
			send_word(word_with_opcode(OP_IMM));
		target = $urandom;
		target[1:0] = 2'b00;
		i_redirect = 1'b1;
		i_redirect_pc = target;
		i_instr_valid = 1'b1; // offered but never taken
		i_instr = $urandom;
		@(negedge i_clock);
		i_redirect = 1'b0;
		i_instr_valid = 1'b0;
		kept = 6 - 3; // the operand read item still leaves on that edge
		check_word("items issued through redirect", 32'(got_q.size() - checked),
			32'(kept));
		while (exp_q.size() > checked + kept)
			void'(exp_q.pop_back());
		pc_model = target;
		for (int n = 0; n < 5; n++)
			send_word(word_with_opcode(OP));
		drain_and_check();
	endtask

	initial begin
		void'($urandom(32'h38873e45));
		i_reset = 1'b1;
		i_instr_valid = 1'b0;
		i_instr = '0;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		i_wb_enable = 1'b0;
		i_wb_rd = '0;
		i_wb_data = '0;
		pc_model = reset_pc;
		repeat (4) @(negedge i_clock);
		i_reset = 1'b0;
		check_word("o_issue_valid", 32'(o_issue_valid), 32'd0);
		check_word("o_instr_ready", 32'(o_instr_ready), 32'd1);
		test_registers(); // also preloads every register
		test_formats();
		test_decode();
		test_backpressure();
		test_redirect();
		$display("** PASS **");
		$finish;
	end

endmodule

// File: rv_frontend.sv
// rv32i instruction front end
module rv_frontend import rv_pkg::*; #(
	parameter word_t reset_pc = 32'h0000_0000
) (
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_instr_valid,
	input  word_t     i_instr,
	input  logic      i_redirect,
	input  word_t     i_redirect_pc,
	input  logic      i_issue_ready,
	input  logic      i_wb_enable,
	input  register_t i_wb_rd,
	input  word_t     i_wb_data,
	output logic      o_instr_ready,
	output logic      o_issue_valid,
	output issue_t    o_issue
);

	logic        flush;
	logic        fetch_valid;
	logic        fetch_ready;
	fetch_data_t fetch_data;
	logic        pre_valid;
	logic        pre_ready;
	fetch_data_t pre_data;
	logic        dec_valid;
	logic        dec_ready;
	decoded_t    dec_data;

	rv_fetch_buffer #(
		.reset_pc(reset_pc)
	) fetch0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_instr_valid(i_instr_valid),
		.i_instr(i_instr),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.i_ready(fetch_ready),
		.o_instr_ready(o_instr_ready),
		.o_valid(fetch_valid),
		.o_data(fetch_data),
		.o_flush(flush)
	);

	rv_predecode predecode0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_flush(flush),
		.i_valid(fetch_valid),
		.i_data(fetch_data),
		.i_ready(pre_ready),
		.o_ready(fetch_ready),
		.o_valid(pre_valid),
		.o_data(pre_data)
	);

	rv_decode decode0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_flush(flush),
		.i_valid(pre_valid),
		.i_data(pre_data),
		.i_ready(dec_ready),
		.o_ready(pre_ready),
		.o_valid(dec_valid),
		.o_data(dec_data)
	);

	rv_operand_read operand0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_flush(flush),
		.i_valid(dec_valid),
		.i_data(dec_data),
		.i_ready(i_issue_ready),
		.i_wb_enable(i_wb_enable),
		.i_wb_rd(i_wb_rd),
		.i_wb_data(i_wb_data),
		.o_ready(dec_ready),
		.o_valid(o_issue_valid),
		.o_data(o_issue)
	);

endmodule

// File: rv_operand_read.sv
// operand read, register file with writeback
module rv_operand_read import rv_pkg::*; (
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_flush,
	input  logic      i_valid,
	input  decoded_t  i_data,
	input  logic      i_ready,
	input  logic      i_wb_enable,
	input  register_t i_wb_rd,
	input  word_t     i_wb_data,
	output logic      o_ready,
	output logic      o_valid,
	output issue_t    o_data
);

	word_t  regs [1:31]; // x0 is not stored
	logic   valid_q;
	issue_t data_q;
	issue_t next;
	logic   load;

	// register value as seen on this edge, including a same-edge write
	function automatic word_t read_reg(input register_t idx);
		word_t value;
		if (idx == 5'd0)
			value = '0;
		else if (i_wb_enable && (i_wb_rd == idx))
			value = i_wb_data;
		else
			value = regs[idx];
		return value;
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_wb_enable && (i_wb_rd != 5'd0))
			regs[i_wb_rd] <= i_wb_data;
	end

	always_comb begin
		next.decoded = i_data;
		next.rs1_value = read_reg(i_data.fetch.rs1);
		next.rs2_value = read_reg(i_data.fetch.rs2);
	end

	assign o_ready = !valid_q || i_ready;
	assign load = i_valid && o_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset || i_flush)
			valid_q <= 1'b0;
		else if (o_ready)
			valid_q <= i_valid;
	end

	// operands are frozen once captured
	always_ff @(posedge i_clock) begin
		if (load)
			data_q <= next;
	end

	assign o_valid = valid_q;
	assign o_data = data_q;

	a_x0_rs1: assert property (@(posedge i_clock) disable iff (i_reset)
		(load && i_wb_enable && (i_wb_rd == 5'd0) && (i_data.fetch.rs1 == 5'd0))
		|=> (o_data.rs1_value == '0));

	a_x0_rs2: assert property (@(posedge i_clock) disable iff (i_reset)
		(load && i_wb_enable && (i_wb_rd == 5'd0) && (i_data.fetch.rs2 == 5'd0))
		|=> (o_data.rs2_value == '0));

endmodule

// File: rv_decode.sv
// decode to operation
module rv_decode import rv_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_flush,
	input  logic        i_valid,
	input  fetch_data_t i_data,
	input  logic        i_ready,
	output logic        o_ready,
	output logic        o_valid,
	output decoded_t    o_data
);

	logic       valid_q;
	decoded_t   data_q;
	decoded_t   next;
	alu_op_t    op;
	logic [2:0] funct3;
	logic       alt; // bit 30, sub and sra select

	assign funct3 = i_data.instruction[14:12];
	assign alt = i_data.instruction[30];

	always_comb begin
		op = INVALID_OP;
		case (i_data.instruction[6:0])
			LUI:   op = LUI_OP;
			AUIPC: op = AUIPC_OP;
			JAL:   op = JAL_OP;
			JALR:  op = (funct3 == 3'b000) ? JALR_OP : INVALID_OP;
			BRANCH: begin
				case (funct3)
					3'b000:  op = BEQ;
					3'b001:  op = BNE;
					3'b100:  op = BLT;
					3'b101:  op = BGE;
					3'b110:  op = BLTU;
					3'b111:  op = BGEU;
					default: op = INVALID_OP;
				endcase
			end
			LOAD:  op = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ?
				LOAD_OP : INVALID_OP;
			STORE: op = (funct3 inside {3'b000, 3'b001, 3'b010}) ? STORE_OP : INVALID_OP;
			OP_IMM: begin
				case (funct3)
					3'b000: op = ADD;
					3'b001: op = alt ? INVALID_OP : SLL;
					3'b010: op = SLT;
					3'b011: op = SLTU;
					3'b100: op = XOR;
					3'b101: op = alt ? SRA : SRL; // srai keeps imm bit 10 set
					3'b110: op = OR;
					3'b111: op = AND;
				endcase
			end
			OP: begin
				case (funct3)
					3'b000: op = alt ? SUB : ADD;
					3'b001: op = alt ? INVALID_OP : SLL;
					3'b010: op = alt ? INVALID_OP : SLT;
					3'b011: op = alt ? INVALID_OP : SLTU;
					3'b100: op = alt ? INVALID_OP : XOR;
					3'b101: op = alt ? SRA : SRL;
					3'b110: op = alt ? INVALID_OP : OR;
					3'b111: op = alt ? INVALID_OP : AND;
				endcase
			end
			MISC_MEM: op = (funct3 == 3'b000) ? FENCE_OP : INVALID_OP;
			SYSTEM:   op = (funct3 != 3'b000) ? CSR_OP : INVALID_OP; // ecall, ebreak not decoded
			default:  op = INVALID_OP;
		endcase
	end

	always_comb begin
		next.fetch = i_data;
		next.op = op;
	end

	assign o_ready = !valid_q || i_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset || i_flush)
			valid_q <= 1'b0;
		else if (o_ready)
			valid_q <= i_valid;
	end

	always_ff @(posedge i_clock) begin
		if (i_valid && o_ready)
			data_q <= next;
	end

	assign o_valid = valid_q;
	assign o_data = data_q;

endmodule

// File: rv_predecode.sv
// pre-decode, format, register indices and immediate
module rv_predecode import rv_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_flush,
	input  logic        i_valid,
	input  fetch_data_t i_data,
	input  logic        i_ready,
	output logic        o_ready,
	output logic        o_valid,
	output fetch_data_t o_data
);

	logic          valid_q;
	fetch_data_t   data_q;
	fetch_data_t   next;
	instr_format_t format;
	word_t         instr;
	logic          have_rs1;
	logic          have_rs2;
	logic          have_rd;
	word_t         imm;

	assign instr = i_data.instruction;

	always_comb begin
		case (instr[6:0])
			OP:       format = FMT_R;
			JALR,
			LOAD,
			OP_IMM,
			MISC_MEM: format = FMT_I;
			STORE:    format = FMT_S;
			BRANCH:   format = FMT_B;
			LUI,
			AUIPC:    format = FMT_U;
			JAL:      format = FMT_J;
			SYSTEM:   format = FMT_CSR;
			default:  format = FMT_NONE;
		endcase
	end

	// which index fields exist in this format
	assign have_rs1 = (format == FMT_R) || (format == FMT_I) || (format == FMT_S) ||
		(format == FMT_B) || (format == FMT_CSR);
	assign have_rs2 = (format == FMT_R) || (format == FMT_S) || (format == FMT_B);
	assign have_rd = (format == FMT_R) || (format == FMT_I) || (format == FMT_U) ||
		(format == FMT_J) || (format == FMT_CSR);

	always_comb begin
		case (format)
			FMT_I:   imm = {{21{instr[31]}}, instr[30:20]}; // shamt sits in the low bits
			FMT_S:   imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			FMT_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			FMT_U:   imm = {instr[31:12], 12'b0};
			FMT_J:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			FMT_CSR: imm = {20'b0, instr[31:20]}; // csr address, zero extended
			default: imm = '0;
		endcase
	end

	always_comb begin
		next = i_data;
		next.format = format;
		next.rs1 = have_rs1 ? instr[19:15] : 5'd0;
		next.rs2 = have_rs2 ? instr[24:20] : 5'd0;
		next.rd = have_rd ? instr[11:7] : 5'd0;
		next.imm = imm;
	end

	assign o_ready = !valid_q || i_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset || i_flush)
			valid_q <= 1'b0;
		else if (o_ready)
			valid_q <= i_valid;
	end

	always_ff @(posedge i_clock) begin
		if (i_valid && o_ready)
			data_q <= next;
	end

	assign o_valid = valid_q;
	assign o_data = data_q;

	// a stalled item must not change under the consumer
	a_hold_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_valid && !i_ready && !i_flush) |=> (o_valid && $stable(o_data)));

endmodule

// File: rv_fetch_buffer.sv
// fetch buffer, pc tagging and redirect
module rv_fetch_buffer import rv_pkg::*; #(
	parameter word_t reset_pc = 32'h0000_0000
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_instr_valid,
	input  word_t       i_instr,
	input  logic        i_redirect,
	input  word_t       i_redirect_pc,
	input  logic        i_ready,
	output logic        o_instr_ready,
	output logic        o_valid,
	output fetch_data_t o_data,
	output logic        o_flush
);

	word_t       pc_next; // pc of the next accepted word
	logic        valid_q;
	fetch_data_t data_q;
	fetch_data_t slot;
	logic        accept;

	// no word is taken on the redirect edge
	assign o_instr_ready = !i_redirect && (!valid_q || i_ready);
	assign accept = i_instr_valid && o_instr_ready;

	always_comb begin
		slot = '0;
		slot.format = FMT_NONE; // filled in by pre-decode
		slot.pc = pc_next;
		slot.instruction = i_instr;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc_next <= reset_pc;
			valid_q <= 1'b0;
		end else if (i_redirect) begin
			pc_next <= i_redirect_pc;
			valid_q <= 1'b0;
		end else begin
			if (accept)
				pc_next <= pc_next + 32'd4;
			if (o_instr_ready)
				valid_q <= i_instr_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept)
			data_q <= slot;
	end

	assign o_valid = valid_q;
	assign o_data = data_q;
	assign o_flush = i_redirect; // later stages drop their items on the same edge

	a_redirect_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
		i_redirect |-> (i_redirect_pc[1:0] == 2'b00));

endmodule

// File: rv_pkg.sv
// rv32i front end shared types
package rv_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] register_t;

	// major opcodes, bits 6:0 of the instruction
	typedef enum logic [6:0] {
		LUI      = 7'b0110111,
		AUIPC    = 7'b0010111,
		JAL      = 7'b1101111,
		JALR     = 7'b1100111,
		BRANCH   = 7'b1100011,
		LOAD     = 7'b0000011,
		STORE    = 7'b0100011,
		OP_IMM   = 7'b0010011,
		OP       = 7'b0110011,
		SYSTEM   = 7'b1110011,
		MISC_MEM = 7'b0001111
	} opcode_t;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J,
		FMT_CSR,
		FMT_NONE
	} instr_format_t;

	typedef enum logic [4:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		LUI_OP,
		AUIPC_OP,
		JAL_OP,
		JALR_OP,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU,
		LOAD_OP,
		STORE_OP,
		CSR_OP,
		FENCE_OP,
		INVALID_OP
	} alu_op_t;

	// fetch fills pc and instruction, pre-decode the rest
	typedef struct packed {
		word_t         pc;
		word_t         instruction;
		instr_format_t format;
		register_t     rs1;
		register_t     rs2;
		register_t     rd;
		word_t         imm;
	} fetch_data_t;

	typedef struct packed {
		fetch_data_t fetch;
		alu_op_t     op;
	} decoded_t;

	typedef struct packed {
		decoded_t decoded;
		word_t    rs1_value;
		word_t    rs2_value;
	} issue_t;

endpackage
